/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ** PASS **

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qxF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* design/data_mem_ctrl.sv */
`timescale 1ns/1ps

module data_mem_ctrl import mem_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      dmem_valid,
    input  logic                      dmem_we,
    input  logic [WORD_BITS-1:0]      dmem_addr,
    input  logic [WORD_BITS-1:0]      dmem_wdata,
    input  logic [BYTES_PER_WORD-1:0] dmem_be,
    output logic                      dmem_ready,
    output logic                      dmem_rvalid,
    output logic [WORD_BITS-1:0]      dmem_rdata,
    output logic                      inv_valid,
    output logic [LINE_IDX_BITS-1:0]  inv_line,
    line_rd_if.req                    mem_rd,
    line_wr_if.req                    mem_wr
);

    dmem_state_e state;

    // latched request
    logic [LINE_IDX_BITS-1:0]  req_line;
    logic [WORD_SEL_BITS-1:0]  req_sel;
    logic [WORD_BITS-1:0]      req_wdata;
    logic [BYTES_PER_WORD-1:0] req_be;

    // store line before and after the merge
    logic [LINE_BITS-1:0] merged_line;
    logic [LINE_BITS-1:0] wr_line;

    logic take;
    logic rsp_load;
    logic rsp_store;

    // accept only when the line read can go out too
    assign dmem_ready = (state == D_IDLE) && mem_rd.req_ready;
    assign take       = dmem_valid && dmem_ready;

    // line read issued with the accept
    // loads and stores both need it
    assign mem_rd.req_valid = (state == D_IDLE) && dmem_valid;
    assign mem_rd.addr      = dmem_addr[LINE_IDX_LSB +: LINE_IDX_BITS];

    assign rsp_load  = (state == D_LOAD) && mem_rd.rsp_valid;
    assign rsp_store = (state == D_RMW_READ) && mem_rd.rsp_valid;

    // write back
    assign mem_wr.valid = (state == D_RMW_WRITE);
    assign mem_wr.addr  = req_line;
    assign mem_wr.wdata = wr_line;

    // fetch buffer drops the line in the write cycle
    assign inv_valid = (state == D_RMW_WRITE);
    assign inv_line  = req_line;

    // byte merge into the addressed word
    always_comb begin
        merged_line = mem_rd.rsp_data;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (req_be[b]) begin
                merged_line[req_sel*WORD_BITS + b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= D_IDLE;
            dmem_rvalid <= 1'b0;
        end else begin
            dmem_rvalid <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (take) begin
                        state <= dmem_we ? D_RMW_READ : D_LOAD;
                    end
                end
                D_LOAD: begin
                    // word goes out the cycle after the line
                    if (rsp_load) begin
                        state       <= D_IDLE;
                        dmem_rvalid <= 1'b1;
                    end
                end
                D_RMW_READ: begin
                    if (rsp_store) begin
                        state <= D_RMW_WRITE;
                    end
                end
                D_RMW_WRITE: begin
                    // stores give no response
                    if (mem_wr.ready) begin
                        state <= D_IDLE;
                    end
                end
                default: begin
                    state <= D_IDLE;
                end
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (take) begin
            req_line  <= dmem_addr[LINE_IDX_LSB +: LINE_IDX_BITS];
            req_sel   <= dmem_addr[WORD_SEL_LSB +: WORD_SEL_BITS];
            req_wdata <= dmem_wdata;
            req_be    <= dmem_be;
        end
        if (rsp_load) begin
            dmem_rdata <= mem_rd.rsp_data[req_sel*WORD_BITS +: WORD_BITS];
        end
        if (rsp_store) begin
            wr_line <= merged_line;
        end
    end

endmodule

/* design/fetch_line_buffer.sv */
`timescale 1ns/1ps

module fetch_line_buffer import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     fetch_valid,
    input  logic [WORD_BITS-1:0]     fetch_addr,
    input  logic                     inv_valid,
    input  logic [LINE_IDX_BITS-1:0] inv_line,
    output logic                     fetch_ready,
    output logic                     fetch_rvalid,
    output logic [WORD_BITS-1:0]     fetch_rdata,
    line_rd_if.req                   mem_rd
);

    fetch_state_e state;

    // the single buffered line
    logic [LINE_BITS-1:0]     buf_data;
    logic [LINE_IDX_BITS-1:0] buf_line;
    logic                     buf_valid;

    // request held across a refill
    logic [LINE_IDX_BITS-1:0] req_line;
    logic [WORD_SEL_BITS-1:0] req_sel;
    logic                     pend_inv;

    logic [LINE_IDX_BITS-1:0] addr_line;
    logic [WORD_SEL_BITS-1:0] addr_sel;
    logic                     take;
    logic                     hit;
    logic                     fill;
    logic                     inv_req;

    assign addr_line = fetch_addr[LINE_IDX_LSB +: LINE_IDX_BITS];
    assign addr_sel  = fetch_addr[WORD_SEL_LSB +: WORD_SEL_BITS];

    // one fetch in flight
    assign fetch_ready = (state == F_IDLE);
    assign take        = fetch_valid && fetch_ready;
    assign hit         = buf_valid && (buf_line == addr_line);
    assign fill        = (state == F_RESP) && mem_rd.rsp_valid;
    // store hitting the line under refill
    assign inv_req     = inv_valid && (inv_line == req_line);

    assign mem_rd.req_valid = (state == F_REFILL);
    assign mem_rd.addr      = req_line;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= F_IDLE;
            buf_valid    <= 1'b0;
            pend_inv     <= 1'b0;
            fetch_rvalid <= 1'b0;
        end else begin
            fetch_rvalid <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (take && hit) begin
                        fetch_rvalid <= 1'b1;
                    end else if (take) begin
                        state    <= F_REFILL;
                        pend_inv <= 1'b0;
                    end
                end
                F_REFILL: begin
                    if (inv_req) begin
                        pend_inv <= 1'b1;
                    end
                    if (mem_rd.req_ready) begin
                        state <= F_RESP;
                    end
                end
                F_RESP: begin
                    if (fill) begin
                        state        <= F_IDLE;
                        fetch_rvalid <= 1'b1;
                        // stale line serves this fetch only
                        buf_valid    <= !(pend_inv || inv_req);
                    end else if (inv_req) begin
                        pend_inv <= 1'b1;
                    end
                end
                default: begin
                    state <= F_IDLE;
                end
            endcase
            // store to the held line drops it
            if (inv_valid && (inv_line == buf_line) && !fill) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (take) begin
            req_line <= addr_line;
            req_sel  <= addr_sel;
        end
        if (take && hit) begin
            fetch_rdata <= buf_data[addr_sel*WORD_BITS +: WORD_BITS];
        end
        if (fill) begin
            buf_data    <= mem_rd.rsp_data;
            buf_line    <= req_line;
            fetch_rdata <= mem_rd.rsp_data[req_sel*WORD_BITS +: WORD_BITS];
        end
    end

endmodule

/* design/line_mem.sv */
`timescale 1ns/1ps

module line_mem import mem_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    line_rd_if.mem imem_rd,
    line_rd_if.mem dmem_rd,
    line_wr_if.mem dmem_wr
);

    // one entry per line
    logic [LINE_BITS-1:0] mem [MEM_LINES];

    logic ready_q;
    logic imem_take;
    logic dmem_take;
    logic wr_take;

    // low in reset, high from the first cycle after
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    // all three ports share the one ready flop
    assign imem_rd.req_ready = ready_q;
    assign dmem_rd.req_ready = ready_q;
    assign dmem_wr.ready     = ready_q;

    assign imem_take = imem_rd.req_valid && imem_rd.req_ready;
    assign dmem_take = dmem_rd.req_valid && dmem_rd.req_ready;
    assign wr_take   = dmem_wr.valid && dmem_wr.ready;

    // response strobes
    // one cycle after the take
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            imem_rd.rsp_valid <= 1'b0;
            dmem_rd.rsp_valid <= 1'b0;
        end else begin
            imem_rd.rsp_valid <= imem_take;
            dmem_rd.rsp_valid <= dmem_take;
        end
    end

    // read data holds between responses
    // same-line write this cycle is not seen yet
    always_ff @(posedge clk) begin
        if (imem_take) begin
            imem_rd.rsp_data <= mem[imem_rd.addr];
        end
        if (dmem_take) begin
            dmem_rd.rsp_data <= mem[dmem_rd.addr];
        end
    end

    // full line write
    always @(posedge clk) begin
        if (wr_take) begin
            mem[dmem_wr.addr] <= dmem_wr.wdata;
        end
    end

    // preset contents for simulation
    initial begin
        for (int i = 0; i < MEM_LINES; i++) begin
            mem[i] = MEM_INIT_PATTERN;
        end
    end

endmodule

/* design/mem_ifs.sv */
`timescale 1ns/1ps

// line read channel
// request with valid/ready, response one cycle later
interface line_rd_if import mem_pkg::*; ();
    // request
    logic                     req_valid;
    logic                     req_ready;
    logic [LINE_IDX_BITS-1:0] addr;
    // response has no back-pressure
    logic                     rsp_valid;
    logic [LINE_BITS-1:0]     rsp_data;

    modport req (
        output req_valid,
        output addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data
    );

    modport mem (
        input  req_valid,
        input  addr,
        output req_ready,
        output rsp_valid,
        output rsp_data
    );
endinterface

// line write channel
// write lands on the edge where valid and ready meet
interface line_wr_if import mem_pkg::*; ();
    logic                     valid;
    logic                     ready;
    logic [LINE_IDX_BITS-1:0] addr;
    logic [LINE_BITS-1:0]     wdata;

    modport req (
        output valid,
        output addr,
        output wdata,
        input  ready
    );

    modport mem (
        input  valid,
        input  addr,
        input  wdata,
        output ready
    );
endinterface

/* design/mem_pkg.sv */
package mem_pkg;

    // line and word geometry
    localparam int LINE_BITS      = 128;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;
    localparam int BYTES_PER_WORD = WORD_BITS / 8;

    // memory depth in lines
    localparam int MEM_LINES     = 256;
    localparam int LINE_IDX_BITS = $clog2(MEM_LINES);

    // byte address fields
    // word select sits right above the byte offset
    localparam int WORD_SEL_LSB  = 2;
    localparam int LINE_IDX_LSB  = 4;
    localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);

    // fill value for every line at time zero
    localparam logic [LINE_BITS-1:0] MEM_INIT_PATTERN = {(LINE_BITS / 8){8'hf0}};

    // fetch buffer FSM
    // refill issues the line read, resp waits for the line
    typedef enum logic [1:0] {
        F_IDLE,
        F_REFILL,
        F_RESP
    } fetch_state_e;

    // data controller FSM
    // load waits for the line, stores go read then write
    typedef enum logic [1:0] {
        D_IDLE,
        D_LOAD,
        D_RMW_READ,
        D_RMW_WRITE
    } dmem_state_e;

endpackage

/* design/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    // instruction fetch port
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  logic [WORD_BITS-1:0]      fetch_addr,
    output logic                      fetch_rvalid,
    output logic [WORD_BITS-1:0]      fetch_rdata,
    // data load/store port
    input  logic                      dmem_valid,
    output logic                      dmem_ready,
    input  logic                      dmem_we,
    input  logic [WORD_BITS-1:0]      dmem_addr,
    input  logic [WORD_BITS-1:0]      dmem_wdata,
    input  logic [BYTES_PER_WORD-1:0] dmem_be,
    output logic                      dmem_rvalid,
    output logic [WORD_BITS-1:0]      dmem_rdata
);

    // store invalidate toward the fetch buffer
    logic                     inv_valid;
    logic [LINE_IDX_BITS-1:0] inv_line;

    // line channels
    line_rd_if imem_rd ();
    line_rd_if dmem_rd ();
    line_wr_if dmem_wr ();

    fetch_line_buffer u_fetch (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .inv_valid    (inv_valid),
        .inv_line     (inv_line),
        .fetch_ready  (fetch_ready),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rdata  (fetch_rdata),
        .mem_rd       (imem_rd)
    );

    data_mem_ctrl u_dmem (
        .clk         (clk),
        .arst_n      (arst_n),
        .dmem_valid  (dmem_valid),
        .dmem_we     (dmem_we),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_be     (dmem_be),
        .dmem_ready  (dmem_ready),
        .dmem_rvalid (dmem_rvalid),
        .dmem_rdata  (dmem_rdata),
        .inv_valid   (inv_valid),
        .inv_line    (inv_line),
        .mem_rd      (dmem_rd),
        .mem_wr      (dmem_wr)
    );

    line_mem u_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .imem_rd (imem_rd),
        .dmem_rd (dmem_rd),
        .dmem_wr (dmem_wr)
    );

endmodule

/* dv/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb import mem_pkg::*; ();

    typedef enum logic [1:0] {
        OP_FETCH,
        OP_LOAD,
        OP_STORE
    } op_kind_e;

    // lat of zero means the latency is not checked
    typedef struct packed {
        op_kind_e             kind;
        logic [WORD_BITS-1:0] addr;
        logic [WORD_BITS-1:0] wdata;
        logic [3:0]           be;
        int                   lat;
    } op_t;

    logic                      clk;
    logic                      arst_n;
    logic                      fetch_valid;
    logic                      fetch_ready;
    logic [WORD_BITS-1:0]      fetch_addr;
    logic                      fetch_rvalid;
    logic [WORD_BITS-1:0]      fetch_rdata;
    logic                      dmem_valid;
    logic                      dmem_ready;
    logic                      dmem_we;
    logic [WORD_BITS-1:0]      dmem_addr;
    logic [WORD_BITS-1:0]      dmem_wdata;
    logic [BYTES_PER_WORD-1:0] dmem_be;
    logic                      dmem_rvalid;
    logic [WORD_BITS-1:0]      dmem_rdata;

    // word-wide shadow of the whole memory
    logic [WORD_BITS-1:0] shadow [MEM_LINES*WORDS_PER_LINE];

    // pending stimulus, then expected responses in request order
    op_t                  ops [$];
    logic [WORD_BITS-1:0] fexp_data [$];
    int                   fexp_cyc [$];
    int                   fexp_lat [$];
    logic [WORD_BITS-1:0] dexp_data [$];
    int                   dexp_cyc [$];

    integer seed;
    int     cyc = 0;
    int     limit = 100000;
    int     n_expected = 0;
    int     n_checked = 0;
    int     f_lat;
    logic   f_fly;
    logic   st_fly;
    logic   f_offer;
    logic   d_offer;

    // request still being served, as seen by the checker
    logic   f_wait;
    int     d_busy;

    mem_subsys_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch_addr   (fetch_addr),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rdata  (fetch_rdata),
        .dmem_valid   (dmem_valid),
        .dmem_ready   (dmem_ready),
        .dmem_we      (dmem_we),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_be      (dmem_be),
        .dmem_rvalid  (dmem_rvalid),
        .dmem_rdata   (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cycle count that bounds the run
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // line index and word select together
    function automatic logic [LINE_IDX_BITS+LINE_IDX_LSB-WORD_SEL_LSB-1:0] word_index(
        input logic [WORD_BITS-1:0] addr
    );
        return addr[LINE_IDX_LSB+LINE_IDX_BITS-1:WORD_SEL_LSB];
    endfunction

    function automatic logic [WORD_BITS-1:0] expected_word(input logic [WORD_BITS-1:0] addr);
        return shadow[word_index(addr)];
    endfunction

    // byte lanes with be set take the new data
    function automatic void apply_store(
        input logic [WORD_BITS-1:0] addr,
        input logic [WORD_BITS-1:0] wdata,
        input logic [3:0]           be
    );
        logic [WORD_BITS-1:0] word;
        word = shadow[word_index(addr)];
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        shadow[word_index(addr)] = word;
    endfunction

    task automatic check_value(
        input string                what,
        input logic [WORD_BITS-1:0] got,
        input logic [WORD_BITS-1:0] exp
    );
        if (got !== exp) begin
            $display("ERROR @ %0t: %s got %h expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic push_op(
        input op_kind_e             kind,
        input logic [WORD_BITS-1:0] addr,
        input logic [WORD_BITS-1:0] wdata,
        input logic [3:0]           be,
        input int                   lat
    );
        op_t op;
        op.kind  = kind;
        op.addr  = addr;
        op.wdata = wdata;
        op.be    = be;
        op.lat   = lat;
        ops.push_back(op);
        if (kind != OP_STORE) begin
            n_expected++;
        end
    endtask

    task automatic build_ops();
        logic [WORD_BITS-1:0] rnd;
        logic [WORD_BITS-1:0] a;
        int                   k;
        // untouched addresses after reset
        push_op(OP_LOAD, 32'h100, 0, 0, 0);
        push_op(OP_LOAD, 32'h5f4, 0, 0, 0);
        push_op(OP_FETCH, 32'h200, 0, 0, 3);
        // full words, then the word and its neighbours
        push_op(OP_STORE, 32'h300, $random(seed), 4'hf, 0);
        push_op(OP_STORE, 32'h304, $random(seed), 4'hf, 0);
        push_op(OP_LOAD, 32'h300, 0, 0, 0);
        push_op(OP_LOAD, 32'h304, 0, 0, 0);
        push_op(OP_LOAD, 32'h2fc, 0, 0, 0);
        push_op(OP_LOAD, 32'h308, 0, 0, 0);
        // partial byte enables merge with old contents
        push_op(OP_STORE, 32'h304, $random(seed), 4'b0101, 0);
        push_op(OP_STORE, 32'h304, $random(seed), 4'b1000, 0);
        push_op(OP_STORE, 32'h310, $random(seed), 4'b0010, 0);
        push_op(OP_LOAD, 32'h304, 0, 0, 0);
        push_op(OP_LOAD, 32'h310, 0, 0, 0);
        // distinct words in the line so a wrong word select shows
        push_op(OP_STORE, 32'h400, $random(seed), 4'hf, 0);
        push_op(OP_STORE, 32'h404, $random(seed), 4'hf, 0);
        push_op(OP_STORE, 32'h408, $random(seed), 4'hf, 0);
        push_op(OP_STORE, 32'h40c, $random(seed), 4'hf, 0);
        // miss, then hits in the same line
        push_op(OP_FETCH, 32'h400, 0, 0, 3);
        push_op(OP_FETCH, 32'h404, 0, 0, 1);
        push_op(OP_FETCH, 32'h408, 0, 0, 1);
        push_op(OP_FETCH, 32'h40c, 0, 0, 1);
        push_op(OP_FETCH, 32'h400, 0, 0, 1);
        // store into the buffered line
        // dropped line refills, then hits again
        push_op(OP_FETCH, 32'h500, 0, 0, 3);
        push_op(OP_STORE, 32'h508, $random(seed), 4'hf, 0);
        push_op(OP_FETCH, 32'h508, 0, 0, 3);
        push_op(OP_FETCH, 32'h500, 0, 0, 1);
        // mixed stream over eight lines so hits and invalidates happen
        for (int i = 0; i < 300; i++) begin
            rnd = $random(seed);
            a   = rnd & 32'h0000_007c;
            k   = {$random(seed)} % 3;
            rnd = $random(seed);
            if (k == 0) begin
                push_op(OP_FETCH, a, 0, 0, 0);
            end else if (k == 1) begin
                push_op(OP_LOAD, a, 0, 0, 0);
            end else begin
                push_op(OP_STORE, a, $random(seed), rnd[3:0], 0);
            end
        end
    endtask

    // one cycle of stimulus
    // handshakes sampled at the falling edge, drive on the rising edge
    task automatic drive_cycle();
        logic                 f_take;
        logic                 d_take;
        logic                 nf_valid;
        logic                 nd_valid;
        logic                 nd_we;
        logic [WORD_BITS-1:0] nf_addr;
        logic [WORD_BITS-1:0] nd_addr;
        logic [WORD_BITS-1:0] nd_wdata;
        logic [3:0]           nd_be;
        op_t                  op;
        @(negedge clk);
        f_take = fetch_valid && fetch_ready;
        d_take = dmem_valid && dmem_ready;
        if (fetch_rvalid) begin
            f_fly = 1'b0;
        end
        // controller idle again, so any store has landed
        if (dmem_ready) begin
            st_fly = 1'b0;
        end
        if (f_take) begin
            fexp_data.push_back(expected_word(fetch_addr));
            fexp_cyc.push_back(cyc);
            fexp_lat.push_back(f_lat);
            f_fly = 1'b1;
        end
        if (d_take && dmem_we) begin
            apply_store(dmem_addr, dmem_wdata, dmem_be);
            st_fly = 1'b1;
        end else if (d_take) begin
            dexp_data.push_back(expected_word(dmem_addr));
            dexp_cyc.push_back(cyc);
        end
        // offers not yet taken stay up
        nf_valid = fetch_valid && !f_take;
        nf_addr  = fetch_addr;
        nd_valid = dmem_valid && !d_take;
        nd_we    = dmem_we;
        nd_addr  = dmem_addr;
        nd_wdata = dmem_wdata;
        nd_be    = dmem_be;
        // stores never overlap a fetch in flight
        if (ops.size() > 0) begin
            op = ops[0];
            if (op.kind == OP_FETCH) begin
                if (!nf_valid && !f_fly && !st_fly && !(nd_valid && nd_we)) begin
                    nf_valid = 1'b1;
                    nf_addr  = op.addr;
                    f_lat    = op.lat;
                    void'(ops.pop_front());
                end
            end else if (!nd_valid && (op.kind == OP_LOAD || (!nf_valid && !f_fly))) begin
                nd_valid = 1'b1;
                nd_we    = (op.kind == OP_STORE);
                nd_addr  = op.addr;
                nd_wdata = op.wdata;
                nd_be    = op.be;
                void'(ops.pop_front());
            end
        end
        @(posedge clk);
        fetch_valid <= nf_valid;
        fetch_addr  <= nf_addr;
        dmem_valid  <= nd_valid;
        dmem_we     <= nd_we;
        dmem_addr   <= nd_addr;
        dmem_wdata  <= nd_wdata;
        dmem_be     <= nd_be;
        f_offer = nf_valid;
        d_offer = nd_valid;
    endtask

    // response checker
    always @(negedge clk) begin : compare
        int acc;
        int lat;
        if (arst_n && fetch_rvalid) begin
            if (fexp_data.size() == 0) begin
                $display("a fetch response arrived with no fetch outstanding");
                $display("** FAIL **");
                $fatal(1, "unexpected fetch response");
            end else begin
                acc = fexp_cyc.pop_front();
                lat = fexp_lat.pop_front();
                check_value("fetch data", fetch_rdata, fexp_data.pop_front());
                if (lat != 0) begin
                    check_value("fetch latency", cyc - acc, lat);
                end
                n_checked++;
            end
        end
        if (arst_n && dmem_rvalid) begin
            if (dexp_data.size() == 0) begin
                $display("a load response arrived with no load outstanding");
                $display("** FAIL **");
                $fatal(1, "unexpected load response");
            end else begin
                acc = dexp_cyc.pop_front();
                check_value("load data", dmem_rdata, dexp_data.pop_front());
                check_value("load latency", cyc - acc, 2);
                n_checked++;
            end
        end
        // fetch port closed until its response
        if (arst_n && f_wait && !fetch_rvalid) begin
            check_value("fetch ready while busy", WORD_BITS'(fetch_ready), '0);
        end
        // data port closed for the load wait or the store read and write
        if (arst_n && d_busy > 0) begin
            check_value("dmem ready while busy", WORD_BITS'(dmem_ready), '0);
            d_busy--;
        end
        if (fetch_rvalid) begin
            f_wait = 1'b0;
        end
        if (fetch_valid && fetch_ready) begin
            f_wait = 1'b1;
        end
        if (dmem_valid && dmem_ready) begin
            d_busy = dmem_we ? 2 : 1;
        end
    end

    initial begin
        seed        = 70027;
        arst_n      = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        dmem_valid  = 1'b0;
        dmem_we     = 1'b0;
        dmem_addr   = '0;
        dmem_wdata  = '0;
        dmem_be     = '0;
        f_fly       = 1'b0;
        st_fly      = 1'b0;
        f_offer     = 1'b0;
        d_offer     = 1'b0;
        f_lat       = 0;
        f_wait      = 1'b0;
        d_busy      = 0;
        for (int i = 0; i < MEM_LINES * WORDS_PER_LINE; i++) begin
            shadow[i] = MEM_INIT_PATTERN[(i % WORDS_PER_LINE)*WORD_BITS +: WORD_BITS];
        end
        build_ops();
        limit = 20 * ops.size();
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        while (ops.size() > 0 || f_offer || d_offer || f_fly || st_fly ||
               dexp_data.size() > 0) begin
            drive_cycle();
        end
        repeat (5) @(posedge clk);
        if (n_checked == n_expected) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("checked %0d responses but expected %0d", n_checked, n_expected);
            $display("** FAIL **");
            $fatal(1, "response count mismatch");
        end
    end

endmodule

/* files.f */
design/mem_pkg.sv
design/mem_ifs.sv
design/line_mem.sv
design/fetch_line_buffer.sv
design/data_mem_ctrl.sv
design/mem_subsys_top.sv
dv/mem_subsys_tb.sv
